// File: Makefile
TOP = ex_stage_tb

.PHONY: all lint sim clean

all: sim

# design only, testbench parsed but not elaborated
lint:
	verilator --lint-only -Wall --timing -f ex_stage.f --top-module ex_stage

# pass only when the testbench prints the pass line
sim:
	verilator --binary --timing -f ex_stage.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "PASS: all tests"

clean:
	rm -rf obj_dir

// File: ex_stage.f
source/ex_pkg.sv
source/ex_stage_reg.sv
source/operand_select.sv
source/exec_alu.sv
source/branch_unit.sv
source/csr_write.sv
source/ex_stage.sv
test/ex_stage_tb.sv

// File: source/branch_unit.sv
`timescale 1ns/1ns

module branch_unit (
    input  logic                       clk,
    input  logic [ex_pkg::op_bits-1:0] op,
    input  logic [ex_pkg::xlen-1:0]    pc,
    input  ex_pkg::ex_inst_u           inst,
    input  logic [ex_pkg::xlen-1:0]    src_a,
    input  logic [ex_pkg::xlen-1:0]    src_b,
    input  logic [ex_pkg::xlen-1:0]    alu_result,
    input  logic                       valid,
    output logic [ex_pkg::xlen-1:0]    dnpc,
    output logic                       pc_update
);

    localparam logic [ex_pkg::xlen-1:0] inst_bytes = 4;

    logic [ex_pkg::xlen-1:0] imm_b;
    logic [ex_pkg::xlen-1:0] snpc;
    logic [ex_pkg::xlen-1:0] target;
    logic                    taken;
    logic                    is_ctrl;

    // b immediate, 13 bits with bit 0 always zero
    assign imm_b = {{(ex_pkg::xlen-12){inst.as_b.sign}}, inst.as_b.imm_11,
                    inst.as_b.imm_10_5, inst.as_b.imm_4_1, 1'b0};
    assign snpc   = pc + inst_bytes;
    assign target = pc + imm_b;

    always_comb begin
        case (op)
            ex_pkg::op_beq:  taken = src_a == src_b;
            ex_pkg::op_bne:  taken = src_a != src_b;
            ex_pkg::op_blt:  taken = $signed(src_a) < $signed(src_b);
            ex_pkg::op_bge:  taken = $signed(src_a) >= $signed(src_b);
            ex_pkg::op_bltu: taken = src_a < src_b;
            ex_pkg::op_bgeu: taken = src_a >= src_b;
            default:         taken = 1'b0;
        endcase
    end

    always_comb begin
        is_ctrl = 1'b1;
        dnpc    = snpc;
        case (op)
            ex_pkg::op_jal:  dnpc = alu_result;
            ex_pkg::op_jalr: dnpc = {alu_result[ex_pkg::xlen-1:1], 1'b0};
            // trap vector or return address arrives on src_b
            ex_pkg::op_ecall, ex_pkg::op_mret: dnpc = src_b;
            ex_pkg::op_beq, ex_pkg::op_bne, ex_pkg::op_blt, ex_pkg::op_bge,
            ex_pkg::op_bltu, ex_pkg::op_bgeu:
                dnpc = taken ? target : snpc;
            default: is_ctrl = 1'b0;
        endcase
    end

    // redirect on every control op, taken or not
    assign pc_update = valid && is_ctrl;

    // stage register zeroes op on a bubble, no control op without valid
    assert property (@(posedge clk) is_ctrl |-> valid);

endmodule

// File: source/csr_write.sv
`timescale 1ns/1ns

module csr_write #(
    parameter logic [ex_pkg::xlen-1:0] ecall_cause = 11
) (
    input  logic                       clk,
    input  logic [ex_pkg::op_bits-1:0] op,
    input  logic [ex_pkg::xlen-1:0]    pc,
    input  ex_pkg::ex_inst_u           inst,
    input  logic [ex_pkg::xlen-1:0]    src_a,
    input  logic [ex_pkg::xlen-1:0]    alu_result,
    output logic                       wen_mtvec,
    output logic                       wen_mepc,
    output logic                       wen_mcause,
    output logic                       wen_mstatus,
    output logic [ex_pkg::xlen-1:0]    wdata_mtvec,
    output logic [ex_pkg::xlen-1:0]    wdata_mepc,
    output logic [ex_pkg::xlen-1:0]    wdata_mcause,
    output logic [ex_pkg::xlen-1:0]    wdata_mstatus
);

    logic [11:0]             addr;
    logic                    is_csrrw;
    logic                    is_csrrs;
    logic                    is_ecall;
    logic                    is_csr;
    logic [ex_pkg::xlen-1:0] csr_data;

    assign addr     = inst.as_i.csr_addr;
    assign is_csrrw = op == ex_pkg::op_csrrw;
    assign is_csrrs = op == ex_pkg::op_csrrs;
    assign is_ecall = op == ex_pkg::op_ecall;
    assign is_csr   = is_csrrw || is_csrrs;

    // csrrs writes old value or rs1, csrrw writes rs1
    assign csr_data = is_csrrs ? alu_result : src_a;

    // mtvec only through csrrw
    assign wen_mtvec   = is_csrrw && addr == ex_pkg::csr_mtvec;
    assign wen_mepc    = (is_csr && addr == ex_pkg::csr_mepc) || is_ecall;
    assign wen_mcause  = (is_csr && addr == ex_pkg::csr_mcause) || is_ecall;
    assign wen_mstatus = is_csr && addr == ex_pkg::csr_mstatus;

    // zero data when not written
    assign wdata_mtvec   = wen_mtvec ? src_a : '0;
    assign wdata_mstatus = wen_mstatus ? csr_data : '0;

    // ecall saves pc and the cause code
    always_comb begin
        wdata_mepc   = '0;
        wdata_mcause = '0;
        if (is_ecall) begin
            wdata_mepc   = pc;
            wdata_mcause = ecall_cause;
        end else begin
            if (wen_mepc) begin
                wdata_mepc = csr_data;
            end
            if (wen_mcause) begin
                wdata_mcause = csr_data;
            end
        end
    end

    // one csr per instruction, ecall the only double write
    assert property (@(posedge clk)
        $onehot0({wen_mtvec, wen_mepc, wen_mcause, wen_mstatus}) || is_ecall);

endmodule

// File: source/ex_pkg.sv
package ex_pkg;

    // data path widths
    localparam int xlen      = 64;
    localparam int word_bits = 32;
    localparam int op_bits   = 6;

    // operation codes, any value not listed here acts as nop
    localparam logic [op_bits-1:0] op_nop   = 6'd0;
    // register forms
    localparam logic [op_bits-1:0] op_add   = 6'd1;
    localparam logic [op_bits-1:0] op_sub   = 6'd2;
    localparam logic [op_bits-1:0] op_slt   = 6'd3;
    localparam logic [op_bits-1:0] op_sltu  = 6'd4;
    localparam logic [op_bits-1:0] op_xor   = 6'd5;
    localparam logic [op_bits-1:0] op_or    = 6'd6;
    localparam logic [op_bits-1:0] op_and   = 6'd7;
    localparam logic [op_bits-1:0] op_sll   = 6'd8;
    localparam logic [op_bits-1:0] op_srl   = 6'd9;
    localparam logic [op_bits-1:0] op_sra   = 6'd10;
    // immediate forms
    localparam logic [op_bits-1:0] op_addi  = 6'd11;
    localparam logic [op_bits-1:0] op_slti  = 6'd12;
    localparam logic [op_bits-1:0] op_sltiu = 6'd13;
    localparam logic [op_bits-1:0] op_xori  = 6'd14;
    localparam logic [op_bits-1:0] op_ori   = 6'd15;
    localparam logic [op_bits-1:0] op_andi  = 6'd16;
    localparam logic [op_bits-1:0] op_slli  = 6'd17;
    localparam logic [op_bits-1:0] op_srli  = 6'd18;
    localparam logic [op_bits-1:0] op_srai  = 6'd19;
    // word forms, result sign-extended from bit 31
    localparam logic [op_bits-1:0] op_addw  = 6'd20;
    localparam logic [op_bits-1:0] op_subw  = 6'd21;
    localparam logic [op_bits-1:0] op_sllw  = 6'd22;
    localparam logic [op_bits-1:0] op_srlw  = 6'd23;
    localparam logic [op_bits-1:0] op_sraw  = 6'd24;
    localparam logic [op_bits-1:0] op_addiw = 6'd25;
    localparam logic [op_bits-1:0] op_slliw = 6'd26;
    localparam logic [op_bits-1:0] op_srliw = 6'd27;
    localparam logic [op_bits-1:0] op_sraiw = 6'd28;
    // upper immediates and jumps
    localparam logic [op_bits-1:0] op_lui   = 6'd29;
    localparam logic [op_bits-1:0] op_auipc = 6'd30;
    localparam logic [op_bits-1:0] op_jal   = 6'd31;
    localparam logic [op_bits-1:0] op_jalr  = 6'd32;
    // branches
    localparam logic [op_bits-1:0] op_beq   = 6'd33;
    localparam logic [op_bits-1:0] op_bne   = 6'd34;
    localparam logic [op_bits-1:0] op_blt   = 6'd35;
    localparam logic [op_bits-1:0] op_bge   = 6'd36;
    localparam logic [op_bits-1:0] op_bltu  = 6'd37;
    localparam logic [op_bits-1:0] op_bgeu  = 6'd38;
    // system
    localparam logic [op_bits-1:0] op_csrrw = 6'd39;
    localparam logic [op_bits-1:0] op_csrrs = 6'd40;
    localparam logic [op_bits-1:0] op_ecall = 6'd41;
    localparam logic [op_bits-1:0] op_mret  = 6'd42;

    // machine csr addresses
    localparam logic [11:0] csr_mtvec   = 12'h305;
    localparam logic [11:0] csr_mepc    = 12'h341;
    localparam logic [11:0] csr_mcause  = 12'h342;
    localparam logic [11:0] csr_mstatus = 12'h300;

    // alu functions
    localparam logic [3:0] fn_add  = 4'd0;
    localparam logic [3:0] fn_sub  = 4'd1;
    localparam logic [3:0] fn_slt  = 4'd2;
    localparam logic [3:0] fn_sltu = 4'd3;
    localparam logic [3:0] fn_xor  = 4'd4;
    localparam logic [3:0] fn_or   = 4'd5;
    localparam logic [3:0] fn_and  = 4'd6;
    localparam logic [3:0] fn_sll  = 4'd7;
    localparam logic [3:0] fn_srl  = 4'd8;
    localparam logic [3:0] fn_sra  = 4'd9;

    // instruction word, read as b-type for branch offsets
    // and as i-type for the csr address and immediate shamt
    typedef union packed {
        struct packed {
            logic       sign;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } as_b;
        struct packed {
            logic [11:0] csr_addr;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } as_i;
    } ex_inst_u;

endpackage

// File: source/ex_stage.sv
`timescale 1ns/1ns

module ex_stage #(
    parameter logic [ex_pkg::xlen-1:0] ecall_cause = 11
) (
    input  logic                       clk,
    input  logic                       rst,
    // from decode
    input  logic                       valid_in,
    input  logic [ex_pkg::xlen-1:0]    pc_in,
    input  ex_pkg::ex_inst_u           inst_in,
    input  logic [ex_pkg::op_bits-1:0] op_in,
    input  logic [ex_pkg::xlen-1:0]    src_a,
    input  logic [ex_pkg::xlen-1:0]    src_b,
    input  logic [ex_pkg::xlen-1:0]    imm,
    // toward memory stage
    output logic                       valid_out,
    output logic [ex_pkg::xlen-1:0]    pc_out,
    output ex_pkg::ex_inst_u           inst_out,
    output logic [ex_pkg::op_bits-1:0] op_out,
    output logic [ex_pkg::xlen-1:0]    src_b_out,
    output logic [ex_pkg::xlen-1:0]    alu_result,
    // redirect toward fetch
    output logic [ex_pkg::xlen-1:0]    dnpc,
    output logic                       pc_update,
    // machine csr writes
    output logic                       wen_mtvec,
    output logic                       wen_mepc,
    output logic                       wen_mcause,
    output logic                       wen_mstatus,
    output logic [ex_pkg::xlen-1:0]    wdata_mtvec,
    output logic [ex_pkg::xlen-1:0]    wdata_mepc,
    output logic [ex_pkg::xlen-1:0]    wdata_mcause,
    output logic [ex_pkg::xlen-1:0]    wdata_mstatus
);

    // valid-gated fields
    logic [ex_pkg::op_bits-1:0] op_g;
    logic [ex_pkg::xlen-1:0]    pc_g;
    logic [ex_pkg::xlen-1:0]    src_a_g;
    logic [ex_pkg::xlen-1:0]    src_b_g;
    logic [ex_pkg::xlen-1:0]    imm_g;
    ex_pkg::ex_inst_u           inst_g;
    // alu operands
    logic [ex_pkg::xlen-1:0]    operand_a;
    logic [ex_pkg::xlen-1:0]    operand_b;
    logic [3:0]                 alu_fn;
    logic                       is_word;
    logic                       upper_half;

    ex_stage_reg u_reg (
        .clk(clk), .rst(rst),
        .valid_in(valid_in), .pc_in(pc_in), .inst_in(inst_in), .op_in(op_in),
        .src_a(src_a), .src_b(src_b), .imm(imm),
        .valid_out(valid_out), .pc_out(pc_out), .inst_out(inst_out),
        .op_out(op_out), .src_b_out(src_b_out),
        .op_g(op_g), .pc_g(pc_g), .src_a_g(src_a_g), .src_b_g(src_b_g),
        .imm_g(imm_g), .inst_g(inst_g)
    );

    operand_select u_opsel (
        .op(op_g), .pc(pc_g), .src_a(src_a_g), .src_b(src_b_g), .imm(imm_g),
        .inst(inst_g), .operand_a(operand_a), .operand_b(operand_b),
        .alu_fn(alu_fn), .is_word(is_word), .upper_half(upper_half)
    );

    exec_alu u_alu (
        .operand_a(operand_a), .operand_b(operand_b), .alu_fn(alu_fn),
        .is_word(is_word), .upper_half(upper_half), .result(alu_result)
    );

    branch_unit u_branch (
        .clk(clk), .op(op_g), .pc(pc_g), .inst(inst_g), .src_a(src_a_g),
        .src_b(src_b_g), .alu_result(alu_result), .valid(valid_out),
        .dnpc(dnpc), .pc_update(pc_update)
    );

    csr_write #(.ecall_cause(ecall_cause)) u_csr (
        .clk(clk), .op(op_g), .pc(pc_g), .inst(inst_g), .src_a(src_a_g),
        .alu_result(alu_result),
        .wen_mtvec(wen_mtvec), .wen_mepc(wen_mepc),
        .wen_mcause(wen_mcause), .wen_mstatus(wen_mstatus),
        .wdata_mtvec(wdata_mtvec), .wdata_mepc(wdata_mepc),
        .wdata_mcause(wdata_mcause), .wdata_mstatus(wdata_mstatus)
    );

endmodule

// File: source/ex_stage_reg.sv
`timescale 1ns/1ns

module ex_stage_reg (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       valid_in,
    input  logic [ex_pkg::xlen-1:0]    pc_in,
    input  ex_pkg::ex_inst_u           inst_in,
    input  logic [ex_pkg::op_bits-1:0] op_in,
    input  logic [ex_pkg::xlen-1:0]    src_a,
    input  logic [ex_pkg::xlen-1:0]    src_b,
    input  logic [ex_pkg::xlen-1:0]    imm,
    output logic                       valid_out,
    output logic [ex_pkg::xlen-1:0]    pc_out,
    output ex_pkg::ex_inst_u           inst_out,
    output logic [ex_pkg::op_bits-1:0] op_out,
    output logic [ex_pkg::xlen-1:0]    src_b_out,
    output logic [ex_pkg::op_bits-1:0] op_g,
    output logic [ex_pkg::xlen-1:0]    pc_g,
    output logic [ex_pkg::xlen-1:0]    src_a_g,
    output logic [ex_pkg::xlen-1:0]    src_b_g,
    output logic [ex_pkg::xlen-1:0]    imm_g,
    output ex_pkg::ex_inst_u           inst_g
);

    // src_a and imm only leave through the gate
    logic [ex_pkg::xlen-1:0] src_a_q;
    logic [ex_pkg::xlen-1:0] imm_q;

    // loads every cycle, no stall path
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
            pc_out    <= '0;
            inst_out  <= '0;
            op_out    <= '0;
            src_a_q   <= '0;
            src_b_out <= '0;
            imm_q     <= '0;
        end else begin
            valid_out <= valid_in;
            pc_out    <= pc_in;
            inst_out  <= inst_in;
            op_out    <= op_in;
            src_a_q   <= src_a;
            src_b_out <= src_b;
            imm_q     <= imm;
        end
    end

    // bubble reads as zero, so op decodes as nop everywhere
    assign op_g    = valid_out ? op_out    : '0;
    assign pc_g    = valid_out ? pc_out    : '0;
    assign src_a_g = valid_out ? src_a_q   : '0;
    assign src_b_g = valid_out ? src_b_out : '0;
    assign imm_g   = valid_out ? imm_q     : '0;
    assign inst_g  = valid_out ? inst_out  : '0;

    // an unknown valid would leak x through every gate
    assert property (@(posedge clk) disable iff (rst) !$isunknown(valid_out));

endmodule

// File: source/exec_alu.sv
`timescale 1ns/1ns

module exec_alu (
    input  logic [ex_pkg::xlen-1:0] operand_a,
    input  logic [ex_pkg::xlen-1:0] operand_b,
    input  logic [3:0]              alu_fn,
    input  logic                    is_word,
    input  logic                    upper_half,
    output logic [ex_pkg::xlen-1:0] result
);

    localparam int pad = ex_pkg::xlen - ex_pkg::word_bits;

    logic [ex_pkg::xlen-1:0] raw;
    logic [5:0]              shamt;
    logic                    lt_s;
    logic                    lt_u;

    assign shamt = operand_b[5:0];
    assign lt_s  = $signed(operand_a) < $signed(operand_b);
    assign lt_u  = operand_a < operand_b;

    // full 64-bit functions
    always_comb begin
        case (alu_fn)
            ex_pkg::fn_add:  raw = operand_a + operand_b;
            ex_pkg::fn_sub:  raw = operand_a - operand_b;
            ex_pkg::fn_slt:  raw = {{(ex_pkg::xlen-1){1'b0}}, lt_s};
            ex_pkg::fn_sltu: raw = {{(ex_pkg::xlen-1){1'b0}}, lt_u};
            ex_pkg::fn_xor:  raw = operand_a ^ operand_b;
            ex_pkg::fn_or:   raw = operand_a | operand_b;
            ex_pkg::fn_and:  raw = operand_a & operand_b;
            ex_pkg::fn_sll:  raw = operand_a << shamt;
            ex_pkg::fn_srl:  raw = operand_a >> shamt;
            ex_pkg::fn_sra:  raw = $unsigned($signed(operand_a) >>> shamt);
            default:         raw = operand_a + operand_b;
        endcase
    end

    // word ops keep 32 bits and sign-extend them
    always_comb begin
        if (!is_word) begin
            result = raw;
        end else if (upper_half) begin
            // sraw form, word came back in the high half
            result = {{pad{raw[ex_pkg::xlen-1]}}, raw[ex_pkg::xlen-1 -: ex_pkg::word_bits]};
        end else begin
            result = {{pad{raw[ex_pkg::word_bits-1]}}, raw[ex_pkg::word_bits-1:0]};
        end
    end

endmodule

// File: source/operand_select.sv
`timescale 1ns/1ns

module operand_select (
    input  logic [ex_pkg::op_bits-1:0] op,
    input  logic [ex_pkg::xlen-1:0]    pc,
    input  logic [ex_pkg::xlen-1:0]    src_a,
    input  logic [ex_pkg::xlen-1:0]    src_b,
    input  logic [ex_pkg::xlen-1:0]    imm,
    input  ex_pkg::ex_inst_u           inst,
    output logic [ex_pkg::xlen-1:0]    operand_a,
    output logic [ex_pkg::xlen-1:0]    operand_b,
    output logic [3:0]                 alu_fn,
    output logic                       is_word,
    output logic                       upper_half
);

    localparam int pad = ex_pkg::xlen - ex_pkg::word_bits;

    // immediate shamt sits in the low i-type immediate bits
    logic [5:0] shamt_imm;

    assign shamt_imm = inst.as_i.csr_addr[5:0];

    always_comb begin
        operand_a = src_a;
        case (op)
            ex_pkg::op_auipc, ex_pkg::op_jal: operand_a = pc;
            ex_pkg::op_lui: operand_a = '0;
            ex_pkg::op_addw, ex_pkg::op_subw, ex_pkg::op_sllw, ex_pkg::op_srlw,
            ex_pkg::op_addiw, ex_pkg::op_slliw, ex_pkg::op_srliw:
                operand_a = {{pad{1'b0}}, src_a[ex_pkg::word_bits-1:0]};
            // word in upper half, arithmetic shift sees its sign
            ex_pkg::op_sraw, ex_pkg::op_sraiw:
                operand_a = {src_a[ex_pkg::word_bits-1:0], {pad{1'b0}}};
            default: operand_a = src_a;
        endcase
    end

    always_comb begin
        operand_b = src_b;
        case (op)
            ex_pkg::op_addi, ex_pkg::op_slti, ex_pkg::op_sltiu, ex_pkg::op_xori,
            ex_pkg::op_ori, ex_pkg::op_andi, ex_pkg::op_addiw, ex_pkg::op_lui,
            ex_pkg::op_auipc, ex_pkg::op_jal, ex_pkg::op_jalr:
                operand_b = imm;
            // 6-bit shift amounts
            ex_pkg::op_sll, ex_pkg::op_srl, ex_pkg::op_sra:
                operand_b = {{(ex_pkg::xlen-6){1'b0}}, src_b[5:0]};
            ex_pkg::op_slli, ex_pkg::op_srli, ex_pkg::op_srai:
                operand_b = {{(ex_pkg::xlen-6){1'b0}}, shamt_imm};
            // 5-bit for word shifts
            ex_pkg::op_sllw, ex_pkg::op_srlw, ex_pkg::op_sraw:
                operand_b = {{(ex_pkg::xlen-5){1'b0}}, src_b[4:0]};
            ex_pkg::op_slliw, ex_pkg::op_srliw, ex_pkg::op_sraiw:
                operand_b = {{(ex_pkg::xlen-5){1'b0}}, shamt_imm[4:0]};
            default: operand_b = src_b;
        endcase
    end

    always_comb begin
        case (op)
            ex_pkg::op_sub, ex_pkg::op_subw, ex_pkg::op_beq, ex_pkg::op_bne,
            ex_pkg::op_blt, ex_pkg::op_bge, ex_pkg::op_bltu, ex_pkg::op_bgeu:
                alu_fn = ex_pkg::fn_sub;
            ex_pkg::op_slt, ex_pkg::op_slti: alu_fn = ex_pkg::fn_slt;
            ex_pkg::op_sltu, ex_pkg::op_sltiu: alu_fn = ex_pkg::fn_sltu;
            ex_pkg::op_xor, ex_pkg::op_xori: alu_fn = ex_pkg::fn_xor;
            // csrrs: old csr value or rs1
            ex_pkg::op_or, ex_pkg::op_ori, ex_pkg::op_csrrs: alu_fn = ex_pkg::fn_or;
            ex_pkg::op_and, ex_pkg::op_andi: alu_fn = ex_pkg::fn_and;
            ex_pkg::op_sll, ex_pkg::op_slli, ex_pkg::op_sllw, ex_pkg::op_slliw:
                alu_fn = ex_pkg::fn_sll;
            ex_pkg::op_srl, ex_pkg::op_srli, ex_pkg::op_srlw, ex_pkg::op_srliw:
                alu_fn = ex_pkg::fn_srl;
            ex_pkg::op_sra, ex_pkg::op_srai, ex_pkg::op_sraw, ex_pkg::op_sraiw:
                alu_fn = ex_pkg::fn_sra;
            default: alu_fn = ex_pkg::fn_add;
        endcase
    end

    assign is_word = op inside {ex_pkg::op_addw, ex_pkg::op_subw, ex_pkg::op_sllw,
                                ex_pkg::op_srlw, ex_pkg::op_sraw, ex_pkg::op_addiw,
                                ex_pkg::op_slliw, ex_pkg::op_srliw, ex_pkg::op_sraiw};
    // sraw result ends up in bits 63:32
    assign upper_half = op inside {ex_pkg::op_sraw, ex_pkg::op_sraiw};

endmodule

// File: test/ex_stage_tb.sv
`timescale 1ns/1ns

module ex_stage_tb;

    localparam int max_vec = 64;
    localparam int reset_cycles = 16;
    localparam int margin_cycles = 20;
    localparam int clk_period = 40;
    localparam logic [ex_pkg::xlen-1:0] cause_ecall = 11;

    logic clk = 1'b0;
    logic rst;

    // dut inputs
    logic                       valid_in;
    logic [ex_pkg::xlen-1:0]    pc_in;
    ex_pkg::ex_inst_u           inst_in;
    logic [ex_pkg::op_bits-1:0] op_in;
    logic [ex_pkg::xlen-1:0]    src_a;
    logic [ex_pkg::xlen-1:0]    src_b;
    logic [ex_pkg::xlen-1:0]    imm;

    // dut outputs
    logic                       valid_out;
    logic [ex_pkg::xlen-1:0]    pc_out;
    ex_pkg::ex_inst_u           inst_out;
    logic [ex_pkg::op_bits-1:0] op_out;
    logic [ex_pkg::xlen-1:0]    src_b_out;
    logic [ex_pkg::xlen-1:0]    alu_result;
    logic [ex_pkg::xlen-1:0]    dnpc;
    logic                       pc_update;
    logic                       wen_mtvec;
    logic                       wen_mepc;
    logic                       wen_mcause;
    logic                       wen_mstatus;
    logic [ex_pkg::xlen-1:0]    wdata_mtvec;
    logic [ex_pkg::xlen-1:0]    wdata_mepc;
    logic [ex_pkg::xlen-1:0]    wdata_mcause;
    logic [ex_pkg::xlen-1:0]    wdata_mstatus;

    // vectors from the data file
    logic [ex_pkg::op_bits-1:0] v_op    [max_vec];
    logic [ex_pkg::xlen-1:0]    v_pc    [max_vec];
    logic [31:0]                v_inst  [max_vec];
    logic [ex_pkg::xlen-1:0]    v_a     [max_vec];
    logic [ex_pkg::xlen-1:0]    v_b     [max_vec];
    logic [ex_pkg::xlen-1:0]    v_imm   [max_vec];
    logic [ex_pkg::xlen-1:0]    v_alu   [max_vec];
    logic [ex_pkg::xlen-1:0]    v_dnpc  [max_vec];
    logic                       v_pcu   [max_vec];
    logic [3:0]                 v_wen   [max_vec];
    logic [ex_pkg::xlen-1:0]    v_wdata [max_vec];

    int n_vec = 0;
    int check_idx = -1;
    int mismatches = 0;
    int failures = 0;
    bit loaded = 1'b0;

    ex_stage #(.ecall_cause(cause_ecall)) u_dut (
        .clk(clk), .rst(rst),
        .valid_in(valid_in), .pc_in(pc_in), .inst_in(inst_in), .op_in(op_in),
        .src_a(src_a), .src_b(src_b), .imm(imm),
        .valid_out(valid_out), .pc_out(pc_out), .inst_out(inst_out),
        .op_out(op_out), .src_b_out(src_b_out), .alu_result(alu_result),
        .dnpc(dnpc), .pc_update(pc_update),
        .wen_mtvec(wen_mtvec), .wen_mepc(wen_mepc),
        .wen_mcause(wen_mcause), .wen_mstatus(wen_mstatus),
        .wdata_mtvec(wdata_mtvec), .wdata_mepc(wdata_mepc),
        .wdata_mcause(wdata_mcause), .wdata_mstatus(wdata_mstatus)
    );

    // 40 ns period
    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_word(input string name, input logic [ex_pkg::xlen-1:0] got,
                              input logic [ex_pkg::xlen-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h (vector %0d)", name, got, exp, check_idx);
            mismatches++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h (vector %0d)", name, got, exp, check_idx);
            mismatches++;
        end
    endtask

    task automatic check_mask(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h (vector %0d)", name, got, exp, check_idx);
            mismatches++;
        end
    endtask

    task automatic check_op(input string name, input logic [ex_pkg::op_bits-1:0] got,
                            input logic [ex_pkg::op_bits-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h (vector %0d)", name, got, exp, check_idx);
            mismatches++;
        end
    endtask

    task automatic check_inst(input string name, input ex_pkg::ex_inst_u got,
                              input ex_pkg::ex_inst_u exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h (vector %0d)", name, got, exp, check_idx);
            mismatches++;
        end
    endtask

    // skips blank lines and lines starting with '#'
    task automatic load_vectors;
        int fd;
        int n;
        string line;
        logic [ex_pkg::op_bits-1:0] f_op;
        logic [31:0] f_inst;
        logic [ex_pkg::xlen-1:0] f_pc;
        logic [ex_pkg::xlen-1:0] f_a;
        logic [ex_pkg::xlen-1:0] f_b;
        logic [ex_pkg::xlen-1:0] f_imm;
        logic [ex_pkg::xlen-1:0] f_alu;
        logic [ex_pkg::xlen-1:0] f_dnpc;
        logic [ex_pkg::xlen-1:0] f_wdata;
        logic f_pcu;
        logic [3:0] f_wen;
        fd = $fopen("test/ex_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open test/ex_testdata.txt");
            failures++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != 8'h23) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f_op, f_pc,
                                f_inst, f_a, f_b, f_imm, f_alu, f_dnpc, f_pcu, f_wen, f_wdata);
                    if (n != 11) begin
                        $display("malformed data line: %s", line);
                        failures++;
                    end else if (n_vec >= max_vec) begin
                        $display("too many vectors in the data file");
                        failures++;
                    end else begin
                        v_op[n_vec] = f_op;
                        v_pc[n_vec] = f_pc;
                        v_inst[n_vec] = f_inst;
                        v_a[n_vec] = f_a;
                        v_b[n_vec] = f_b;
                        v_imm[n_vec] = f_imm;
                        v_alu[n_vec] = f_alu;
                        v_dnpc[n_vec] = f_dnpc;
                        v_pcu[n_vec] = f_pcu;
                        v_wen[n_vec] = f_wen;
                        v_wdata[n_vec] = f_wdata;
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_vector(input int i);
        valid_in <= 1'b1;
        op_in    <= v_op[i];
        pc_in    <= v_pc[i];
        inst_in  <= v_inst[i];
        src_a    <= v_a[i];
        src_b    <= v_b[i];
        imm      <= v_imm[i];
    endtask

    // bubble carries an ecall and junk fields that the stage must ignore
    task automatic drive_bubble(input logic [31:0] junk);
        valid_in <= 1'b0;
        op_in    <= ex_pkg::op_ecall;
        pc_in    <= {junk, junk};
        inst_in  <= junk;
        src_a    <= {2{junk}};
        src_b    <= {2{~junk}};
        imm      <= {32'h0, junk};
    endtask

    // gated pc is zero during reset and bubbles so dnpc reads 4
    task automatic check_idle;
        check_bit("valid_out", valid_out, 1'b0);
        check_bit("pc_update", pc_update, 1'b0);
        check_mask("wen", {wen_mtvec, wen_mepc, wen_mcause, wen_mstatus}, 4'h0);
        check_word("dnpc", dnpc, 64'h4);
    endtask

    task automatic check_vector(input int i);
        logic [3:0] m;
        m = v_wen[i];
        check_bit("valid_out", valid_out, 1'b1);
        check_word("pc_out", pc_out, v_pc[i]);
        check_inst("inst_out", inst_out, v_inst[i]);
        check_op("op_out", op_out, v_op[i]);
        check_word("src_b_out", src_b_out, v_b[i]);
        check_word("alu_result", alu_result, v_alu[i]);
        check_word("dnpc", dnpc, v_dnpc[i]);
        check_bit("pc_update", pc_update, v_pcu[i]);
        check_mask("wen", {wen_mtvec, wen_mepc, wen_mcause, wen_mstatus}, m);
        // unwritten csr data reads zero
        check_word("wdata_mtvec", wdata_mtvec, m[3] ? v_wdata[i] : '0);
        check_word("wdata_mepc", wdata_mepc, m[2] ? v_wdata[i] : '0);
        // mepc and mcause together only on ecall
        check_word("wdata_mcause", wdata_mcause,
                   m[1] ? (m[2] ? cause_ecall : v_wdata[i]) : '0);
        check_word("wdata_mstatus", wdata_mstatus, m[0] ? v_wdata[i] : '0);
    endtask

    task automatic check_slot(input int kind, input int idx);
        check_idx = idx;
        if (kind == 1) begin
            check_idle();
        end else if (kind == 2) begin
            check_vector(idx);
        end
    endtask

    initial begin
        logic [31:0] rnd;
        int idx;
        int this_kind;
        int this_idx;
        int prev_kind;
        int prev_idx;
        rnd = 32'd27410;
        rst <= 1'b1;
        valid_in <= 1'b0;
        op_in <= '0;
        pc_in <= '0;
        inst_in <= '0;
        src_a <= '0;
        src_b <= '0;
        imm <= '0;
        load_vectors();
        loaded = 1'b1;
        repeat (reset_cycles - 1) @(posedge clk);
        @(negedge clk);
        check_slot(1, -1);
        @(posedge clk);
        rst <= 1'b0;
        // register holds idle inputs right after reset
        prev_kind = 1;
        prev_idx = -1;
        idx = 0;
        while (idx < n_vec) begin
            rnd = xorshift32(rnd);
            @(posedge clk);
            if (rnd[1:0] == 2'b00) begin
                drive_bubble(rnd);
                this_kind = 1;
                this_idx = -1;
            end else begin
                drive_vector(idx);
                this_kind = 2;
                this_idx = idx;
                idx++;
            end
            // outputs now show the slot driven one edge earlier
            @(negedge clk);
            check_slot(prev_kind, prev_idx);
            prev_kind = this_kind;
            prev_idx = this_idx;
        end
        @(posedge clk);
        drive_bubble(rnd);
        @(negedge clk);
        check_slot(prev_kind, prev_idx);
        @(posedge clk);
        @(negedge clk);
        check_slot(1, -1);
        if (n_vec == 0) begin
            $display("no vectors were loaded");
            failures++;
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // room for as many bubbles as vectors plus reset and drain
    initial begin
        wait (loaded);
        #((2 * n_vec + reset_cycles + margin_cycles) * clk_period);
        $display("timeout: stimulus did not complete within the expected time");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: test/ex_testdata.txt
# op pc inst src_a src_b imm | expected alu_result dnpc pc_update wen wdata (all hex)
# wen bits: 3 mtvec, 2 mepc, 1 mcause, 0 mstatus; wdata of the enabled csr, mepc for ecall
01 1000 003100b3 5 7 0 c 1004 0 0 0
02 1008 403100b3 3 5 0 fffffffffffffffe 100c 0 0 0
03 100c 0 fffffffffffffffe 1 0 1 1010 0 0 0
04 1010 0 fffffffffffffffe 1 0 0 1014 0 0 0
05 1014 0 ff00 ff0 0 f0f0 1018 0 0 0
07 101c 0 ff00 ff0 0 f00 1020 0 0 0
08 1020 0 1 43 0 8 1024 0 0 0
09 1024 0 8000000000000000 3f 0 1 1028 0 0 0
0a 1028 0 8000000000000000 4 0 f800000000000000 102c 0 0 0
0b 102c 0 10 99 fffffffffffffff0 0 1030 0 0 0
0c 1030 0 5 0 6 1 1034 0 0 0
0d 1034 0 5 0 ffffffffffffffff 1 1038 0 0 0
0e 1038 0 ff 0 ffffffffffffffff ffffffffffffff00 103c 0 0 0
10 1040 0 1234 0 ff 34 1044 0 0 0
11 1044 00451513 1234 0 4 12340 1048 0 0 0
12 1048 03c55513 f000000000000000 0 3c f 104c 0 0 0
13 104c 40855513 8000000000000000 0 8 ff80000000000000 1050 0 0 0
14 1050 0 123456787fffffff 1 0 ffffffff80000000 1054 0 0 0
16 1058 0 1 3f 0 ffffffff80000000 105c 0 0 0
17 105c 0 ffffffff80000000 4 0 8000000 1060 0 0 0
18 1060 0 80000000 4 0 fffffffff8000000 1064 0 0 0
19 1064 0 fffffffe 0 3 1 1068 0 0 0
1a 1068 01f5151b 3 0 1f ffffffff80000000 106c 0 0 0
1c 1070 4015551b ffffffff 0 1 ffffffffffffffff 1074 0 0 0
1d 1074 800000b7 55 0 ffffffff80000000 ffffffff80000000 1078 0 0 0
1e 1078 00002097 0 0 2000 3078 107c 0 0 0
1f 107c 100000ef 0 0 100 117c 117c 1 0 0
20 117c 010080e7 2001 0 10 2011 2010 1 0 0
21 2010 00000863 7 7 0 0 2020 1 0 0
22 2020 00001863 7 7 0 0 2024 1 0 0
23 2024 fe004ce3 ffffffffffffffff 1 0 fffffffffffffffe 201c 1 0 0
24 201c fe005ce3 ffffffffffffffff 1 0 fffffffffffffffe 2020 1 0 0
25 2020 fe006ce3 ffffffffffffffff 1 0 fffffffffffffffe 2024 1 0 0
26 2024 fe007ce3 ffffffffffffffff 1 0 fffffffffffffffe 201c 1 0 0
27 3000 30559073 8000 0 0 8000 3004 0 8 8000
28 3004 3005a073 8 1800 0 1808 3008 0 1 1808
27 3008 34159073 4000 10 0 4010 300c 0 4 4000
28 300c 3425a073 2 1 0 3 3010 0 2 3
28 3010 3055a073 4 100 0 104 3014 0 0 0
29 3014 00000073 0 8000 0 8000 8000 1 6 3014
2a 8000 30200073 0 3018 0 3018 3018 1 0 0
00 3018 00000013 5 6 0 b 301c 0 0 0
3f 301c 0 1 2 0 3 3020 0 0 0
